// File: rp_frontend_config.svh
// front end sizing constants, included by the package and by every RTL file
`ifndef RP_FRONTEND_CONFIG_SVH
`define RP_FRONTEND_CONFIG_SVH

////////////////////
// sample format
////////////////////

// converter and generator sample width
`define RP_SMP_W 14

// number of analog channels
`define RP_CHANNELS 2

////////////////////
// calibration
////////////////////

// gain word width, signed
`define RP_MUL_W 16
// gain fraction bits, 1 << RP_MUL_FRAC is unity
`define RP_MUL_FRAC 14

`endif

// File: rp_frontend_pkg.sv
// shared sample, gain, pin and code types plus the path mode enum for the front end
`default_nettype none

`include "rp_frontend_config.svh"

package rp_frontend_pkg;

  ////////////////////
  // data types
  ////////////////////

  // signed sample, -8192..8191 at 14 bits
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // signed calibration gain
  typedef logic signed [`RP_MUL_W-1:0] mul_t;

  // raw converter word, bits 15:2 of the ADC bus
  typedef logic [`RP_SMP_W-1:0] adc_pin_t;

  // inverted offset-binary DAC code
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  ////////////////////
  // control
  ////////////////////

  // acquire source select
  typedef enum logic {
    PATH_ADC  = 1'b0,
    PATH_LOOP = 1'b1
  } path_mode_e;

endpackage : rp_frontend_pkg

`default_nettype wire

// File: adc_capture.sv
// first acquire stage, registers the raw ADC word as a signed sample and applies loopback
`default_nettype none
`timescale 1ns/100ps

`include "rp_frontend_config.svh"

module adc_capture
  import rp_frontend_pkg::*;
(
  input  wire logic       adc_clk,
  input  wire logic       top_rst,
  // raw converter word
  input  wire adc_pin_t   pin_i,
  // calibrated generator stream
  input  wire smp_t       loop_i,
  // source select
  input  wire path_mode_e mode_i,
  // to acquire calibration
  output smp_t            smp_o
);

  // converted pin word, one cycle after the pins
  smp_t raw_q;

  ////////////////////
  // input register
  ////////////////////

  // msb kept, lower bits inverted gives two's complement
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      raw_q <= {pin_i[`RP_SMP_W-1], ~pin_i[`RP_SMP_W-2:0]};
    end
  end

  ////////////////////
  // loopback mux
  ////////////////////

  // combinational, no extra cycle in loopback
  always_comb begin
    case (mode_i)
      PATH_LOOP: smp_o = loop_i;
      default:   smp_o = raw_q;
    endcase
  end

  // an unknown select would corrupt the whole acquire pipeline downstream
  a_mode_known : assert property (
    @(posedge adc_clk) disable iff (top_rst) !$isunknown(mode_i)
  );

endmodule : adc_capture

`default_nettype wire

// File: linear_calib.sv
// two-stage gain and offset pipeline with saturation, one instance per path and channel
`default_nettype none
`timescale 1ns/100ps

`include "rp_frontend_config.svh"

module linear_calib
  import rp_frontend_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic top_rst,
  // sample in
  input  wire smp_t smp_i,
  // gain, unity at 1 << RP_MUL_FRAC
  input  wire mul_t mul_i,
  // offset
  input  wire smp_t sum_i,
  // calibrated sample, two cycles later
  output smp_t      smp_o
);

  // full product width
  localparam int PROD_W = $bits(smp_t) + $bits(mul_t);
  // one guard bit for the offset add
  localparam int SUM_W = PROD_W + 1;

  // saturation bounds, widened to the sum
  localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2 ** (`RP_SMP_W - 1) - 1);
  localparam logic signed [SUM_W-1:0] SAT_MIN = ~SAT_MAX;

  // stage one
  logic signed [PROD_W-1:0] prod_q;
  smp_t                     sum_q;

  // stage two, combinational part
  logic signed [PROD_W-1:0] shift_w;
  logic signed [SUM_W-1:0]  add_w;
  smp_t                     sat_w;

  // stage two register
  smp_t                     out_q;

  ////////////////////
  // stage one
  ////////////////////

  // offset travels with its product
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      sum_q  <= '0;
    end else begin
      prod_q <= smp_i * mul_i;
      sum_q  <= sum_i;
    end
  end

  ////////////////////
  // stage two
  ////////////////////

  // arithmetic shift floors negative products
  assign shift_w = prod_q >>> `RP_MUL_FRAC;
  assign add_w   = SUM_W'(shift_w) + SUM_W'(sum_q);

  // clamp to the sample range
  always_comb begin
    if (add_w > SAT_MAX) begin
      sat_w = smp_t'(SAT_MAX);
    end else if (add_w < SAT_MIN) begin
      sat_w = smp_t'(SAT_MIN);
    end else begin
      sat_w = smp_t'(add_w);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      out_q <= '0;
    end else begin
      out_q <= sat_w;
    end
  end

  assign smp_o = out_q;

  // in-range sums must pass through the clamp unchanged
  a_no_false_clip : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (add_w <= SAT_MAX && add_w >= SAT_MIN) |=> (SUM_W'(smp_o) == $past(add_w))
  );

endmodule : linear_calib

`default_nettype wire

// File: dac_format.sv
// last generate stage, registers the calibrated sample as an inverted offset-binary DAC code
`default_nettype none
`timescale 1ns/100ps

`include "rp_frontend_config.svh"

module dac_format
  import rp_frontend_pkg::*;
(
  input  wire logic  adc_clk,
  input  wire logic  top_rst,
  // calibrated generator sample
  input  wire smp_t  smp_i,
  // code to the converter pins
  output dac_code_t  code_o
);

  // code of a zero sample, 8191 at 14 bits
  localparam dac_code_t DAC_ZERO = {1'b0, {(`RP_SMP_W-1){1'b1}}};

  // output register
  dac_code_t code_q;

  ////////////////////
  // format and register
  ////////////////////

  // sign kept, magnitude bits inverted
  // falling code for rising sample, matches the board's inverting output stage
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      code_q <= DAC_ZERO;
    end else begin
      code_q <= {smp_i[`RP_SMP_W-1], ~smp_i[`RP_SMP_W-2:0]};
    end
  end

  assign code_o = code_q;

  // pins never see X once out of reset
  a_code_known : assert property (
    @(posedge adc_clk) disable iff (top_rst) !$isunknown(code_o)
  );

endmodule : dac_format

`default_nettype wire

// File: rp_frontend_top.sv
// front end top level, per channel capture, two calibrations, DAC format and loopback
`default_nettype none
`timescale 1ns/100ps

`include "rp_frontend_config.svh"

module rp_frontend_top
  import rp_frontend_pkg::*;
(
  input  wire logic                          adc_clk,
  input  wire logic                          top_rst,
  // ADC pins
  input  wire adc_pin_t  [`RP_CHANNELS-1:0]  adc_dat_i,
  // generator samples
  input  wire smp_t      [`RP_CHANNELS-1:0]  asg_i,
  // loopback select, shared by all channels
  input  wire path_mode_e                    path_mode_i,
  // acquire calibration
  input  wire mul_t      [`RP_CHANNELS-1:0]  adc_mul_i,
  input  wire smp_t      [`RP_CHANNELS-1:0]  adc_sum_i,
  // generate calibration
  input  wire mul_t      [`RP_CHANNELS-1:0]  dac_mul_i,
  input  wire smp_t      [`RP_CHANNELS-1:0]  dac_sum_i,
  // calibrated acquire samples
  output smp_t           [`RP_CHANNELS-1:0]  osc_o,
  // DAC codes, channels in parallel
  output dac_code_t      [`RP_CHANNELS-1:0]  dac_dat_o
);

  ////////////////////
  // per channel
  ////////////////////

  for (genvar ch = 0; ch < `RP_CHANNELS; ch++) begin : gen_ch

    // capture output, into acquire calibration
    smp_t adc_smp;
    // calibrated generator stream, to DAC and loopback
    smp_t gen_smp;

    // acquire path
    // pins to sample, 1 cycle
    adc_capture i_capture (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .pin_i   (adc_dat_i[ch]),
      .loop_i  (gen_smp),
      .mode_i  (path_mode_i),
      .smp_o   (adc_smp)
    );

    // 2 cycles, 3 from the pins
    linear_calib i_calib_adc (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (adc_smp),
      .mul_i   (adc_mul_i[ch]),
      .sum_i   (adc_sum_i[ch]),
      .smp_o   (osc_o[ch])
    );

    // generate path
    // 2 cycles
    linear_calib i_calib_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (asg_i[ch]),
      .mul_i   (dac_mul_i[ch]),
      .sum_i   (dac_sum_i[ch]),
      .smp_o   (gen_smp)
    );

    // 1 cycle, 3 from asg_i
    dac_format i_format (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_smp),
      .code_o  (dac_dat_o[ch])
    );

  end : gen_ch

endmodule : rp_frontend_top

`default_nettype wire

// File: tb_rp_frontend.sv
// self-checking testbench for the front end, runs a directed table then random streams
`default_nettype none
`timescale 1ns/100ps

`include "rp_frontend_config.svh"

module tb_rp_frontend
  import rp_frontend_pkg::*;
();

  localparam int CH = `RP_CHANNELS;
  localparam int CLK_PERIOD = 40;
  // each table entry is held this long, longer than any path latency
  localparam int HOLD_CYC = 6;
  localparam int NUM_ENTRIES = 10;
  localparam int RAND_LEN = 200;
  localparam int DAC_LAT = 3;
  localparam int UNITY = 1 << `RP_MUL_FRAC;
  localparam int SMP_MAX = (1 << (`RP_SMP_W - 1)) - 1;
  localparam int SMP_MIN = -(1 << (`RP_SMP_W - 1));
  localparam int WATCHDOG_CYC = NUM_ENTRIES * HOLD_CYC + 2 * RAND_LEN + 50;

  logic                    adc_clk;
  logic                    top_rst;
  adc_pin_t  [CH-1:0]      adc_dat;
  smp_t      [CH-1:0]      asg;
  path_mode_e              path_mode;
  mul_t      [CH-1:0]      adc_mul;
  smp_t      [CH-1:0]      adc_sum;
  mul_t      [CH-1:0]      dac_mul;
  smp_t      [CH-1:0]      dac_sum;
  smp_t      [CH-1:0]      osc;
  dac_code_t [CH-1:0]      dac_dat;

  // one directed case, coefficients shared by both channels
  typedef struct packed {
    path_mode_e         mode;
    adc_pin_t  [CH-1:0] pin;
    smp_t      [CH-1:0] asg;
    mul_t               amul;
    smp_t               asum;
    mul_t               dmul;
    smp_t               dsum;
    smp_t      [CH-1:0] exp_osc;
    dac_code_t [CH-1:0] exp_dac;
  } entry_t;

  entry_t tbl [NUM_ENTRIES];
  string  tbl_name [NUM_ENTRIES];
  int     n_entries;
  int     err_cnt;
  int     pass_cnt;
  int     fail_cnt;
  int     errs;
  integer seed;

  rp_frontend_top i_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .asg_i       (asg),
    .path_mode_i (path_mode),
    .adc_mul_i   (adc_mul),
    .adc_sum_i   (adc_sum),
    .dac_mul_i   (dac_mul),
    .dac_sum_i   (dac_sum),
    .osc_o       (osc),
    .dac_dat_o   (dac_dat)
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  ////////////////////
  // reference model
  ////////////////////

  // msb kept and low bits inverted works out to 8191 minus the pin word
  function automatic smp_t conv_pin(input adc_pin_t p);
    return smp_t'(SMP_MAX - int'(p));
  endfunction

  function automatic smp_t calib_model(input smp_t s, input mul_t m, input smp_t o);
    longint prod;
    longint q;
    longint r;
    prod = longint'(s) * longint'(m);
    // floor, toward minus infinity
    if (prod >= 0) begin
      q = prod / UNITY;
    end else begin
      q = -((-prod + UNITY - 1) / UNITY);
    end
    r = q + longint'(o);
    if (r > SMP_MAX) r = SMP_MAX;
    if (r < SMP_MIN) r = SMP_MIN;
    return smp_t'(r);
  endfunction

  // inverted offset binary, again 8191 minus the sample
  function automatic dac_code_t code_model(input smp_t s);
    return dac_code_t'(SMP_MAX - int'(s));
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_smp(input string what, input int ch, input smp_t got, input smp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %0t ns: %s ch%0d got %0d expected %0d", $time, what, ch, got, exp);
    end
  endtask

  task automatic check_code(input string what, input int ch, input dac_code_t got,
                            input dac_code_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %0t ns: %s ch%0d got %0d expected %0d", $time, what, ch, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic set_inputs(input path_mode_e mode, input adc_pin_t [CH-1:0] pin,
                            input smp_t [CH-1:0] gen_in, input mul_t [CH-1:0] amul,
                            input smp_t [CH-1:0] asum, input mul_t [CH-1:0] dmul,
                            input smp_t [CH-1:0] dsum);
    path_mode = mode;
    adc_dat   = pin;
    asg       = gen_in;
    adc_mul   = amul;
    adc_sum   = asum;
    dac_mul   = dmul;
    dac_sum   = dsum;
  endtask

  // even channels take the first value, odd the second
  task automatic add_entry(input string name, input path_mode_e mode, input int pin0,
                           input int pin1, input int asg0, input int asg1, input int amul,
                           input int asum, input int dmul, input int dsum);
    entry_t e;
    smp_t   gen;
    e.mode = mode;
    e.amul = mul_t'(amul);
    e.asum = smp_t'(asum);
    e.dmul = mul_t'(dmul);
    e.dsum = smp_t'(dsum);
    for (int ch = 0; ch < CH; ch++) begin
      e.pin[ch] = adc_pin_t'((ch % 2 == 0) ? pin0 : pin1);
      e.asg[ch] = smp_t'((ch % 2 == 0) ? asg0 : asg1);
      gen = calib_model(e.asg[ch], e.dmul, e.dsum);
      e.exp_dac[ch] = code_model(gen);
      if (mode == PATH_LOOP) begin
        e.exp_osc[ch] = calib_model(gen, e.amul, e.asum);
      end else begin
        e.exp_osc[ch] = calib_model(conv_pin(e.pin[ch]), e.amul, e.asum);
      end
    end
    tbl[n_entries] = e;
    tbl_name[n_entries] = name;
    n_entries++;
  endtask

  task automatic build_table();
    add_entry("raw zero and max", PATH_ADC, 0, 8191, 0, 100, UNITY, 0, UNITY, 0);
    add_entry("raw mid and top", PATH_ADC, 8192, 16383, -100, 8191, UNITY, 0, UNITY, 0);
    add_entry("half gain offset", PATH_ADC, 3000, 12000, 2000, -2000, UNITY / 2, -100,
              UNITY / 2, 40);
    // odd negative products must round down
    add_entry("negative floor", PATH_ADC, 8194, 8200, -3, -9, UNITY / 2, 0, UNITY / 2, 0);
    add_entry("gain saturation", PATH_ADC, 0, 16383, 8000, -8000, 32767, 0, 32767, 0);
    add_entry("offset saturation", PATH_ADC, 100, 16000, 0, -5, UNITY, 8191, UNITY, -8192);
    // raw words are junk here and must not show up
    add_entry("loopback unity", PATH_LOOP, 5555, 1, 1000, -2000, UNITY, 0, UNITY, 0);
    add_entry("loopback scaled", PATH_LOOP, 0, 16383, 4000, -4001, 20000, -30, UNITY / 2, 50);
    add_entry("loopback saturated", PATH_LOOP, 42, 42, 8191, -8192, UNITY, 8191, UNITY, 8191);
    add_entry("negative gain", PATH_ADC, 300, 9000, 8191, -8192, -UNITY, 0, -UNITY, 0);
  endtask

  // random stream, coefficients fixed per run, expected values delayed through queues
  task automatic run_random(input path_mode_e mode, input string name);
    int                 errs_before;
    int                 osc_lat;
    adc_pin_t  [CH-1:0] pin;
    smp_t      [CH-1:0] gen_in;
    mul_t      [CH-1:0] amul;
    smp_t      [CH-1:0] asum;
    mul_t      [CH-1:0] dmul;
    smp_t      [CH-1:0] dsum;
    smp_t      [CH-1:0] e_osc;
    dac_code_t [CH-1:0] e_dac;
    smp_t      [CH-1:0] osc_q [$];
    dac_code_t [CH-1:0] dac_q [$];
    smp_t               gen;
    errs_before = err_cnt;
    // loopback adds the generate calibration in front
    osc_lat = (mode == PATH_LOOP) ? 4 : 3;
    for (int ch = 0; ch < CH; ch++) begin
      amul[ch] = mul_t'(UNITY / 2 + $random(seed) % UNITY);
      asum[ch] = smp_t'($random(seed) % 1024);
      dmul[ch] = mul_t'(UNITY / 2 + $random(seed) % UNITY);
      dsum[ch] = smp_t'($random(seed) % 1024);
    end
    for (int n = 0; n < RAND_LEN; n++) begin
      if (osc_q.size() == osc_lat) begin
        e_osc = osc_q.pop_front();
        for (int ch = 0; ch < CH; ch++) check_smp({name, " osc"}, ch, osc[ch], e_osc[ch]);
      end
      if (dac_q.size() == DAC_LAT) begin
        e_dac = dac_q.pop_front();
        for (int ch = 0; ch < CH; ch++) check_code({name, " dac"}, ch, dac_dat[ch], e_dac[ch]);
      end
      for (int ch = 0; ch < CH; ch++) begin
        pin[ch] = adc_pin_t'($random(seed));
        gen_in[ch] = smp_t'($random(seed));
        gen = calib_model(gen_in[ch], dmul[ch], dsum[ch]);
        e_dac[ch] = code_model(gen);
        if (mode == PATH_LOOP) begin
          e_osc[ch] = calib_model(gen, amul[ch], asum[ch]);
        end else begin
          e_osc[ch] = calib_model(conv_pin(pin[ch]), amul[ch], asum[ch]);
        end
      end
      set_inputs(mode, pin, gen_in, amul, asum, dmul, dsum);
      osc_q.push_back(e_osc);
      dac_q.push_back(e_dac);
      @(negedge adc_clk);
    end
    report_test(name, errs_before);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed      = 69;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    n_entries = 0;
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    set_inputs(PATH_ADC, '0, '0, {CH{mul_t'(UNITY)}}, '0, {CH{mul_t'(UNITY)}}, '0);
    build_table();
    repeat (4) @(negedge adc_clk);

    // still in reset, zero sample and its code
    errs = err_cnt;
    for (int ch = 0; ch < CH; ch++) begin
      check_smp("reset osc", ch, osc[ch], '0);
      check_code("reset dac", ch, dac_dat[ch], dac_code_t'(SMP_MAX));
    end
    report_test("reset values", errs);
    top_rst = 1'b0;

    for (int i = 0; i < n_entries; i++) begin
      errs = err_cnt;
      set_inputs(tbl[i].mode, tbl[i].pin, tbl[i].asg, {CH{tbl[i].amul}}, {CH{tbl[i].asum}},
                 {CH{tbl[i].dmul}}, {CH{tbl[i].dsum}});
      repeat (HOLD_CYC) @(negedge adc_clk);
      for (int ch = 0; ch < CH; ch++) begin
        check_smp({tbl_name[i], " osc"}, ch, osc[ch], tbl[i].exp_osc[ch]);
        check_code({tbl_name[i], " dac"}, ch, dac_dat[ch], tbl[i].exp_dac[ch]);
      end
      report_test(tbl_name[i], errs);
    end

    run_random(PATH_ADC, "random adc stream");
    run_random(PATH_LOOP, "random loopback stream");

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog, sized from the table and the random run lengths
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_rp_frontend

`default_nettype wire

// File: rp_frontend.f
+incdir+.
rp_frontend_pkg.sv
adc_capture.sv
linear_calib.sv
dac_format.sv
rp_frontend_top.sv
tb_rp_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with Verilator, run it, and grade the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_frontend \
  -f rp_frontend.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1
